// ==== verification/proj_cases.txt ====
// m00 m01 m02 m10 m11 m12 m20 m21 m22 x y range_out exp_x exp_y (coefficients 8.8)
// Identity and translation
0100 0000 0000 0000 0100 0000 0000 0000 0100 005 007 0 005 007
0100 0000 0000 0000 0100 0000 0000 0000 0100 27f 1df 0 27f 1df
0100 0000 0000 0000 0100 0000 0000 0000 0100 000 000 0 000 000
0100 0000 0000 0000 0100 0000 0000 0000 0100 280 000 1 000 000
0100 0000 0000 0000 0100 0000 0000 0000 0100 000 1e0 1 000 000
0100 0000 0a00 0000 0100 1400 0000 0000 0100 064 032 0 06e 046
0100 0000 f000 0000 0100 f800 0000 0000 0100 014 01e 0 004 016
0100 0000 f000 0000 0100 f800 0000 0000 0100 00a 01e 1 000 000
0100 0000 0080 0000 0100 00c0 0000 0000 0100 003 004 0 003 004
0100 0000 ff80 0000 0100 0000 0000 0000 0100 000 000 0 000 000
// Scaling
0200 0000 0000 0000 0200 0000 0000 0000 0100 064 0c8 0 0c8 190
0200 0000 0000 0000 0200 0000 0000 0000 0100 140 00a 1 000 000
0080 0000 0000 0000 0080 0000 0000 0000 0100 12d 04d 0 096 026
0040 0000 0000 0000 0040 0000 0000 0000 0100 3ff 3ff 0 0ff 0ff
// Perspective and mixed terms
0100 0000 0000 0000 0100 0000 0000 0000 0200 065 037 0 032 01b
0100 0000 0000 0000 0100 0000 0001 0000 0100 100 064 0 080 032
0100 0000 0000 0000 0100 0000 0000 0002 0100 12c 0c8 0 075 04e
0100 0040 0500 ffc0 0100 3200 0002 0001 0100 0c8 078 0 04d 027
00dd ff80 6400 0080 00dd 0a00 0000 0000 0100 096 05a 0 0b8 0a2
0100 0000 0000 0000 ff00 7f00 0000 0000 0100 006 064 0 006 01b
0100 0000 0000 0000 ff00 0000 0000 0000 0100 005 001 1 000 000
0100 0000 0000 0000 0100 0000 0000 0000 0080 13f 0ef 0 27e 1de
0100 0000 0000 0000 0100 0000 0000 0000 0080 140 000 1 000 000
// Behind the plane and overflow
0100 0000 0000 0000 0100 0000 0000 0000 0000 00a 00a 1 000 000
0100 0000 0000 0000 0100 0000 0000 0000 ff00 005 005 1 000 000
0100 0000 0000 0000 0100 0000 ffff 0000 0100 12c 000 1 000 000
0100 0000 0000 0000 0100 0000 0000 0000 0001 00a 00a 1 000 000
7fff 0000 0000 0000 0100 0000 0000 0000 0001 3ff 000 1 000 000

// ==== list.f ====
rtl/proj_pkg.sv
rtl/homog_mac.sv
rtl/coord_divider.sv
rtl/range_check.sv
rtl/projective_transformation.sv
verification/tb_checker.sv
verification/tb_projective_transformation.sv

// ==== Makefile ====
TOP := tb_projective_transformation

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f list.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir

// ==== verification/tb_projective_transformation.sv ====
module tb_projective_transformation;
	import proj_pkg::*;

	localparam int CLK_PERIOD  = 20;
	localparam int CASE_FIELDS = 14;  // Nine coefficients, x, y, range_out, x, y.
	localparam int MAX_CASES   = 64;
	localparam int LATENCY     = 17;

	logic         clk;
	logic         reset;
	logic         cke;
	matrix_t      matrix;
	logic         s_valid;
	src_point_t   s_point;
	logic         s_ready;
	logic         m_valid;
	out_point_t   m_point;
	logic         m_ready;
	logic         exp_range_out;
	dst_coord_t   exp_x;
	dst_coord_t   exp_y;
	int           error_count;
	int           pending;

	logic [31:0]  case_mem [0:CASE_FIELDS*MAX_CASES-1];
	int           n_cases;
	logic [31:0]  lfsr_state;

	projective_transformation u_projective_transformation (
		.clk     (clk),
		.reset   (reset),
		.cke     (cke),
		.matrix  (matrix),
		.s_valid (s_valid),
		.s_point (s_point),
		.s_ready (s_ready),
		.m_valid (m_valid),
		.m_point (m_point),
		.m_ready (m_ready)
	);

	tb_checker u_checker (
		.clk           (clk),
		.reset         (reset),
		.cke           (cke),
		.s_valid       (s_valid),
		.s_ready       (s_ready),
		.s_point       (s_point),
		.exp_range_out (exp_range_out),
		.exp_x         (exp_x),
		.exp_y         (exp_y),
		.m_valid       (m_valid),
		.m_ready       (m_ready),
		.m_point       (m_point),
		.error_count   (error_count),
		.pending       (pending)
	);

	// ####################################################################
	// Clock, random bits, case driver
	// ####################################################################

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	function automatic logic [31:0] galois_step(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	endfunction

	function automatic logic take_bit();
		take_bit = lfsr_state[0];
		lfsr_state = galois_step(lfsr_state);
	endfunction

	// True about one time in four.
	function automatic logic quarter_chance();
		logic a;
		logic b;
		a = take_bit();
		b = take_bit();
		return !(a | b);
	endfunction

	task automatic drive_case(input int idx);
		int base;
		base = idx * CASE_FIELDS;
		for (int c = 0; c < 9; c++) begin
			matrix[143-16*c -: 16] = case_mem[base+c][15:0];  // m00 sits on top.
		end
		s_point = '{user: user_t'(idx), x: case_mem[base+9][9:0], y: case_mem[base+10][9:0]};
		exp_range_out = case_mem[base+11][0];
		exp_x = case_mem[base+12][11:0];
		exp_y = case_mem[base+13][11:0];
	endtask

	task automatic run_pass(input logic stalls);
		int idx;
		idx = 0;
		while (idx < n_cases) begin
			drive_case(idx);
			s_valid = !quarter_chance();
			cke     = stalls ? !quarter_chance() : 1'b1;
			m_ready = stalls ? !quarter_chance() : 1'b1;
			@(posedge clk);
			if (s_valid && s_ready && cke) begin
				idx++;
			end
			#2;
		end
	endtask

	// ####################################################################
	// Main sequence and watchdog
	// ####################################################################

	initial begin
		reset = 1'b1;
		cke = 1'b1;
		m_ready = 1'b1;
		s_valid = 1'b0;
		matrix = '0;
		s_point = '0;
		exp_range_out = 1'b0;
		exp_x = '0;
		exp_y = '0;
		lfsr_state = 32'hdf;
		n_cases = 0;
		for (int i = 0; i < CASE_FIELDS*MAX_CASES; i++) begin
			case_mem[i] = 32'hffffffff;  // No field in the file is this wide.
		end
		$readmemh("verification/proj_cases.txt", case_mem);
		while (n_cases < MAX_CASES && case_mem[n_cases*CASE_FIELDS] != 32'hffffffff) begin
			n_cases++;
		end
		if (n_cases > 0) begin
			drive_case(0);
			s_valid = 1'b1;  // Offered all through reset.
		end
		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;
		if (n_cases == 0) begin
			$display("No cases could be read from verification/proj_cases.txt");
		end else begin
			run_pass(1'b0);
			run_pass(1'b1);
			s_valid = 1'b0;
			cke = 1'b1;
			m_ready = 1'b1;
			wait (pending == 0);
			repeat (LATENCY + 2) @(posedge clk);  // Catch stray outputs.
		end
		$display("Summary: %0d errors, %0d missing outputs", error_count, pending);
		if (n_cases > 0 && error_count == 0 && pending == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		wait (n_cases > 0);
		#((n_cases + LATENCY) * 8 * CLK_PERIOD);
		$display("The run timed out with %0d outputs still outstanding", pending);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== verification/tb_checker.sv ====
module tb_checker (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 cke,
	input  logic                 s_valid,
	input  logic                 s_ready,
	input  proj_pkg::src_point_t s_point,
	input  logic                 exp_range_out,
	input  proj_pkg::dst_coord_t exp_x,
	input  proj_pkg::dst_coord_t exp_y,
	input  logic                 m_valid,
	input  logic                 m_ready,
	input  proj_pkg::out_point_t m_point,
	output int                   error_count,
	output int                   pending
);
	import proj_pkg::*;

	localparam int LATENCY = 17;  // Two MAC, fourteen divider, one range stage.

	out_point_t exp_q   [$];
	int         stamp_q [$];
	int         adv_count;
	logic       held_valid;
	logic       reset_seen;
	out_point_t held_point;
	out_point_t exp_point;
	int         stamp;

	initial begin
		error_count = 0;
		pending = 0;
		adv_count = 0;
		held_valid = 1'b0;
		reset_seen = 1'b0;
	end

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected) begin
			$display("Error %s: got %0h, expected %0h", name, got, expected);
			error_count++;
		end
	endtask

	// ####################################################################
	// Sampling at each rising edge
	// ####################################################################

	always @(posedge clk) begin
		// Ready is the downstream ready passed straight through.
		check_value("s_ready", 64'(s_ready), 64'(m_ready));

		if (reset) begin
			if (reset_seen) begin
				check_value("m_valid", 64'(m_valid), 64'h0);
			end
			reset_seen = 1'b1;
			held_valid = 1'b0;
		end else begin
			// A stalled output must not move.
			if (held_valid) begin
				if (!m_valid) begin
					$display("m_valid dropped while the pipeline was stalled");
					error_count++;
				end else begin
					check_value("m_point", 64'(m_point), 64'(held_point));
				end
			end

			if (cke && m_ready) begin
				adv_count++;
			end

			if (s_valid && s_ready && cke) begin
				exp_q.push_back('{user: s_point.user, range_out: exp_range_out,
					x: exp_x, y: exp_y});
				stamp_q.push_back(adv_count);
			end

			if (m_valid && m_ready && cke) begin
				if (exp_q.size() == 0) begin
					$display("An output arrived with no point in flight");
					error_count++;
				end else begin
					exp_point = exp_q.pop_front();
					stamp = stamp_q.pop_front();
					check_value("m_point.user", 64'(m_point.user), 64'(exp_point.user));
					check_value("m_point.range_out", 64'(m_point.range_out),
						64'(exp_point.range_out));
					if (!exp_point.range_out) begin
						check_value("m_point.x", 64'(m_point.x), 64'(exp_point.x));
						check_value("m_point.y", 64'(m_point.y), 64'(exp_point.y));
					end
					if (adv_count - stamp != LATENCY) begin
						$display("Point with tag %0d took %0d advancing cycles instead of %0d",
							exp_point.user, adv_count - stamp, LATENCY);
						error_count++;
					end
				end
			end

			held_valid = m_valid && !(cke && m_ready);
			held_point = m_point;
			pending = exp_q.size();
		end
	end

endmodule

// ==== rtl/projective_transformation.sv ====
module projective_transformation (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 cke,
	input  proj_pkg::matrix_t    matrix,
	input  logic                 s_valid,
	input  proj_pkg::src_point_t s_point,
	output logic                 s_ready,
	output logic                 m_valid,
	output proj_pkg::out_point_t m_point,
	input  logic                 m_ready
);
	import proj_pkg::*;

	logic         advance;
	logic         homog_valid;
	homog_point_t homog_point;
	logic         den_not_pos;
	logic         div_valid;
	dst_coord_t   div_x;
	dst_coord_t   div_y;
	logic         div_ovf_x;
	logic         div_ovf_y;
	user_t        div_user;
	logic         div_behind;
	dst_point_t   dst_point;

	assign advance     = cke & m_ready;   // One stall for every stage.
	assign s_ready     = m_ready;
	assign den_not_pos = (homog_point.den <= 0);

	homog_mac u_homog_mac (
		.clk       (clk),
		.reset     (reset),
		.advance   (advance),
		.matrix    (matrix),
		.in_valid  (s_valid),
		.in_point  (s_point),
		.out_valid (homog_valid),
		.out_point (homog_point)
	);

	// ####################################################################
	// Dividers, x carries the tag and the behind flag
	// ####################################################################

	coord_divider u_div_x (
		.clk       (clk),
		.reset     (reset),
		.advance   (advance),
		.in_valid  (homog_valid),
		.num       (homog_point.num_x),
		.den       (homog_point.den),
		.in_user   (homog_point.user),
		.in_side   (den_not_pos),
		.out_valid (div_valid),
		.quotient  (div_x),
		.overflow  (div_ovf_x),
		.out_user  (div_user),
		.out_side  (div_behind)
	);

	coord_divider u_div_y (
		.clk       (clk),
		.reset     (reset),
		.advance   (advance),
		.in_valid  (homog_valid),
		.num       (homog_point.num_y),
		.den       (homog_point.den),
		.in_user   (homog_point.user),
		.in_side   (1'b0),
		.out_valid (),
		.quotient  (div_y),
		.overflow  (div_ovf_y),
		.out_user  (),
		.out_side  ()
	);

	assign dst_point = '{
		user:   div_user,
		x:      div_x,
		y:      div_y,
		ovf_x:  div_ovf_x,
		ovf_y:  div_ovf_y,
		behind: div_behind
	};

	range_check u_range_check (
		.clk       (clk),
		.reset     (reset),
		.advance   (advance),
		.in_valid  (div_valid),
		.in_point  (dst_point),
		.out_valid (m_valid),
		.out_point (m_point)
	);

endmodule

// ==== rtl/range_check.sv ====
module range_check (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 advance,
	input  logic                 in_valid,
	input  proj_pkg::dst_point_t in_point,
	output logic                 out_valid,
	output proj_pkg::out_point_t out_point
);
	import proj_pkg::*;

	logic outside;

	always_comb begin
		outside = in_point.behind
			|| in_point.ovf_x
			|| in_point.ovf_y
			|| (in_point.x < 0)
			|| (in_point.y < 0)
			|| (in_point.x >= dst_coord_t'(FRAME_WIDTH))
			|| (in_point.y >= dst_coord_t'(FRAME_HEIGHT));
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (advance) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			out_point <= '{
				user:      in_point.user,
				range_out: outside,
				x:         in_point.x,    // Don't care when outside.
				y:         in_point.y
			};
		end
	end

endmodule

// ==== rtl/coord_divider.sv ====
module coord_divider (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 advance,
	input  logic                 in_valid,
	input  proj_pkg::homog_t     num,
	input  proj_pkg::homog_t     den,
	input  proj_pkg::user_t      in_user,
	input  logic                 in_side,
	output logic                 out_valid,
	output proj_pkg::dst_coord_t quotient,
	output logic                 overflow,
	output proj_pkg::user_t      out_user,
	output logic                 out_side
);
	import proj_pkg::*;

	localparam int LAST = DIV_STAGES - 2;        // Index of the last subtract stage.
	localparam int WIDE = HOMOG_W + QUOT_BITS;   // Room for the shifted divisor.

	mag_t  num_mag;
	mag_t  den_mag;
	logic  too_big;

	logic  st_valid [0:LAST];
	mag_t  st_rem   [0:LAST-1];
	mag_t  st_den   [0:LAST-1];
	quot_t st_quot  [0:LAST];
	logic  st_neg   [0:LAST];
	logic  st_ovf   [0:LAST];
	user_t st_user  [0:LAST];
	logic  st_side  [0:LAST];

	wire       step_take [1:LAST];
	wire mag_t step_rem  [1:LAST-1];

	// ####################################################################
	// Magnitudes and range precheck
	// ####################################################################

	always_comb begin
		num_mag = num[HOMOG_W-1] ? mag_t'(-num) : mag_t'(num);
		den_mag = den[HOMOG_W-1] ? mag_t'(-den) : mag_t'(den);
		// Quotient needs more than QUOT_BITS bits; a zero divisor lands here too.
		too_big = (num_mag >> QUOT_BITS) >= den_mag;
	end

	// ####################################################################
	// Restoring steps, MSB first
	// ####################################################################

	for (genvar k = 1; k <= LAST; k++) begin : g_step
		localparam int BIT = LAST - k;
		logic [WIDE-1:0] trial;

		assign trial        = {{QUOT_BITS{1'b0}}, st_den[k-1]} << BIT;
		assign step_take[k] = {{QUOT_BITS{1'b0}}, st_rem[k-1]} >= trial;

		if (k < LAST) begin : g_rem
			assign step_rem[k] = step_take[k] ? st_rem[k-1] - trial[HOMOG_W-1:0]
				: st_rem[k-1];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int k = 0; k <= LAST; k++) begin
				st_valid[k] <= 1'b0;
			end
			out_valid <= 1'b0;
		end else if (advance) begin
			st_valid[0] <= in_valid;
			for (int k = 1; k <= LAST; k++) begin
				st_valid[k] <= st_valid[k-1];
			end
			out_valid <= st_valid[LAST];
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			st_rem[0]  <= num_mag;
			st_den[0]  <= den_mag;
			st_quot[0] <= '0;
			st_neg[0]  <= num[HOMOG_W-1];
			st_ovf[0]  <= too_big;
			st_user[0] <= in_user;
			st_side[0] <= in_side;

			for (int k = 1; k < LAST; k++) begin
				st_rem[k] <= step_rem[k];
				st_den[k] <= st_den[k-1];
			end

			for (int k = 1; k <= LAST; k++) begin
				st_quot[k] <= st_quot[k-1] | (quot_t'(step_take[k]) << (LAST - k));
				st_neg[k]  <= st_neg[k-1];
				st_ovf[k]  <= st_ovf[k-1];
				st_user[k] <= st_user[k-1];
				st_side[k] <= st_side[k-1];
			end

			// Sign follows the numerator.
			quotient <= st_neg[LAST] ? -dst_coord_t'(st_quot[LAST])
				: dst_coord_t'(st_quot[LAST]);
			overflow <= st_ovf[LAST] | st_quot[LAST][QUOT_BITS-1];  // Top bit is the sign.
			out_user <= st_user[LAST];
			out_side <= st_side[LAST];
		end
	end

endmodule

// ==== rtl/homog_mac.sv ====
module homog_mac (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   advance,
	input  proj_pkg::matrix_t      matrix,
	input  logic                   in_valid,
	input  proj_pkg::src_point_t   in_point,
	output logic                   out_valid,
	output proj_pkg::homog_point_t out_point
);
	import proj_pkg::*;

	// Term r is num_x, num_y, den for r = 0, 1, 2.
	coef_t  coef_x [3];
	coef_t  coef_y [3];
	coef_t  coef_c [3];

	logic   s1_valid;
	user_t  s1_user;
	homog_t s1_px  [3];
	homog_t s1_py  [3];
	homog_t s1_pc  [3];

	logic   s2_valid;
	user_t  s2_user;
	homog_t s2_sum [3];

	function automatic homog_t mul(input coef_t c, input src_coord_t v);
		homog_t cs;
		homog_t vs;
		cs = homog_t'(c);
		vs = homog_t'(v);  // Coordinate is unsigned.
		return cs * vs;
	endfunction

	always_comb begin
		coef_x = '{matrix.m00, matrix.m10, matrix.m20};
		coef_y = '{matrix.m01, matrix.m11, matrix.m21};
		coef_c = '{matrix.m02, matrix.m12, matrix.m22};
	end

	// ####################################################################
	// Valid pipe
	// ####################################################################

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else if (advance) begin
			s1_valid <= in_valid;
			s2_valid <= s1_valid;
		end
	end

	// ####################################################################
	// Products, then sums
	// ####################################################################

	always_ff @(posedge clk) begin
		if (advance) begin
			s1_user <= in_point.user;
			for (int r = 0; r < 3; r++) begin
				s1_px[r] <= mul(coef_x[r], in_point.x);
				s1_py[r] <= mul(coef_y[r], in_point.y);
				// Raw 8.8 value is the offset times one pixel.
				s1_pc[r] <= homog_t'(coef_c[r]);
			end

			s2_user <= s1_user;
			for (int r = 0; r < 3; r++) begin
				s2_sum[r] <= s1_px[r] + s1_py[r] + s1_pc[r];
			end
		end
	end

	assign out_valid = s2_valid;
	assign out_point = '{
		user:  s2_user,
		num_x: s2_sum[0],
		num_y: s2_sum[1],
		den:   s2_sum[2]
	};

endmodule

// ==== rtl/proj_pkg.sv ====
package proj_pkg;

	// ####################################################################
	// Widths and frame
	// ####################################################################

	localparam int COEF_W    = 16;
	localparam int SRC_W     = 10;
	localparam int DST_W     = 12;
	localparam int USER_W    = 8;
	localparam int HOMOG_W   = 30;
	localparam int QUOT_BITS = 12;  // Quotient bits out of the divider.

	localparam int FRAME_WIDTH  = 640;
	localparam int FRAME_HEIGHT = 480;

	localparam int DIV_STAGES   = QUOT_BITS + 2;    // Magnitude, steps, sign.
	localparam int PIPE_LATENCY = 2 + DIV_STAGES + 1;

	typedef logic signed [COEF_W-1:0]    coef_t;  // 8.8 fixed point.
	typedef logic        [SRC_W-1:0]     src_coord_t;
	typedef logic signed [DST_W-1:0]     dst_coord_t;
	typedef logic        [USER_W-1:0]    user_t;
	typedef logic signed [HOMOG_W-1:0]   homog_t;  // 8 fraction bits.
	typedef logic        [HOMOG_W-1:0]   mag_t;
	typedef logic        [QUOT_BITS-1:0] quot_t;

	// ####################################################################
	// Point and matrix records
	// ####################################################################

	typedef struct packed {
		coef_t m00;
		coef_t m01;
		coef_t m02;
		coef_t m10;
		coef_t m11;
		coef_t m12;
		coef_t m20;
		coef_t m21;
		coef_t m22;
	} matrix_t;

	typedef struct packed {
		user_t      user;
		src_coord_t x;
		src_coord_t y;
	} src_point_t;

	typedef struct packed {
		user_t  user;
		homog_t num_x;
		homog_t num_y;
		homog_t den;
	} homog_point_t;

	typedef struct packed {
		user_t      user;
		dst_coord_t x;
		dst_coord_t y;
		logic       ovf_x;
		logic       ovf_y;
		logic       behind;
	} dst_point_t;

	typedef struct packed {
		user_t      user;
		logic       range_out;
		dst_coord_t x;
		dst_coord_t y;
	} out_point_t;

endpackage
